/* include/vdp_defines.svh */
// --------------------------------------------------
// compositor sizing macros
// layer count, pixel and colour widths, palette depth
// register map addresses for the AXI4-Lite port
// --------------------------------------------------
`ifndef VDP_DEFINES_SVH
`define VDP_DEFINES_SVH

// palette index carried by every layer pixel
`define VDP_PIXEL_W 8
// RGB565 output colour
`define VDP_COLOR_W 16
`define VDP_PALETTE_DEPTH 256
// scroll 0..3 plus the sprite layer
`define VDP_LAYERS 5

// register map, byte addresses
`define VDP_REG_LAYER_EN 12'h000
`define VDP_REG_PALETTE_BASE 12'h400

`endif

/* logic/vdp_layer_pkg.sv */
// --------------------------------------------------
// layer types for the pixel path
// layer index enum, input pixel set, selection
// --------------------------------------------------
`include "vdp_defines.svh"

package vdp_layer_pkg;

    // bit positions in the one-hot layer mask and selection
    typedef enum logic [2:0] {
        SCROLL0 = 3'd0,
        SCROLL1 = 3'd1,
        SCROLL2 = 3'd2,
        SCROLL3 = 3'd3,
        SPRITES = 3'd4
    } layer_e;

    // one pixel clock worth of layer input, 42 bits
    typedef struct packed {
        // scroll[0] is the top scroll layer
        logic [3:0][`VDP_PIXEL_W-1:0] scroll;
        logic [`VDP_PIXEL_W-1:0]      sprite;
        // sprite priority against the scroll layers
        logic [1:0]                   sprite_prio;
    } layer_pixels_t;

    // winning layer after priority resolution
    typedef struct packed {
        // one-hot, all zero when only the backdrop remains
        logic [`VDP_LAYERS-1:0]  layer;
        logic [`VDP_PIXEL_W-1:0] pixel;
        logic [1:0]              prio;
    } layer_select_t;

endpackage

/* logic/vdp_bus_pkg.sv */
// --------------------------------------------------
// AXI4-Lite register port types
// request and response channel structs, resp codes
// --------------------------------------------------

package vdp_bus_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // master to slave signals of all five channels
    typedef struct packed {
        logic [11:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [11:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // slave to master signals
    typedef struct packed {
        logic        awready;
        logic        wready;
        axil_resp_e  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        axil_resp_e  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

/* logic/vdp_layer_opacity.sv */
// --------------------------------------------------
// first pixel pipeline stage
// registers the layer pixels and builds the
// opaque-and-enabled layer mask
// --------------------------------------------------
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_layer_opacity (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        pix_valid,
    input  vdp_layer_pkg::layer_pixels_t pix_in,
    input  logic [`VDP_LAYERS-1:0]      layer_en,
    output logic                        mask_valid,
    output vdp_layer_pkg::layer_pixels_t pixels,
    output logic [`VDP_LAYERS-1:0]      layer_mask
);

    logic [`VDP_LAYERS-1:0] mask_next;

    // a layer counts when enabled and its low nibble is nonzero
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            mask_next[n] = layer_en[n] && (pix_in.scroll[n][3:0] != 4'h0);
        end
        mask_next[vdp_layer_pkg::SPRITES] = layer_en[vdp_layer_pkg::SPRITES] &&
                                            (pix_in.sprite[3:0] != 4'h0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mask_valid <= 1'b0;
        end else begin
            mask_valid <= pix_valid;
        end
    end

    // payload registers follow the strobe
    always_ff @(posedge clk) begin
        pixels     <= pix_in;
        layer_mask <= mask_next;
    end

    // a valid pixel set and the enables it meets must be fully known
    a_pix_known: assert property (@(posedge clk) disable iff (!arst_n)
        pix_valid |-> !$isunknown({pix_in, layer_en}));

endmodule

/* logic/vdp_layer_priority_select.sv */
// --------------------------------------------------
// priority resolution between scroll and sprites
// purely combinational, one-hot selection output
// --------------------------------------------------
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_layer_priority_select (
    input  logic [`VDP_LAYERS-1:0]       layer_mask,
    input  vdp_layer_pkg::layer_pixels_t pixels,
    output vdp_layer_pkg::layer_select_t selection
);

    logic sprite_opaque;
    logic scroll_found;

    assign sprite_opaque = layer_mask[vdp_layer_pkg::SPRITES];

    always_comb begin
        selection    = '0;
        scroll_found = 1'b0;

        // walk from the top scroll layer down, first opaque one decides
        for (int n = 0; n < 4; n++) begin
            if (!scroll_found && layer_mask[n]) begin
                scroll_found = 1'b1;
                // sprite sits above scroll n when its priority beats 3 - n
                if (sprite_opaque && (int'(pixels.sprite_prio) > 3 - n)) begin
                    selection.layer[vdp_layer_pkg::SPRITES] = 1'b1;
                end else begin
                    selection.layer[n] = 1'b1;
                end
                // resolved priority is the rank of the deciding scroll layer
                selection.prio = 2'(3 - n);
            end
        end

        // no scroll layer visible, sprite only competes with the backdrop
        if (!scroll_found && sprite_opaque) begin
            selection.layer[vdp_layer_pkg::SPRITES] = 1'b1;
            selection.prio = pixels.sprite_prio;
        end

        // pixel of the winner, stays 0 so the backdrop uses palette entry 0
        for (int n = 0; n < 4; n++) begin
            if (selection.layer[n]) begin
                selection.pixel = pixels.scroll[n];
            end
        end
        if (selection.layer[vdp_layer_pkg::SPRITES]) begin
            selection.pixel = pixels.sprite;
        end
    end

endmodule

/* logic/vdp_palette_ram.sv */
// --------------------------------------------------
// 256 x RGB565 palette
// registered read for the pixel path
// write port fed by the register block
// --------------------------------------------------
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_palette_ram (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         rd_valid,
    input  vdp_layer_pkg::layer_select_t rd_select,
    input  logic                         we,
    input  logic [`VDP_PIXEL_W-1:0]      waddr,
    input  logic [`VDP_COLOR_W-1:0]      wdata,
    output logic                         out_valid,
    output logic [`VDP_COLOR_W-1:0]      out_color,
    output logic [`VDP_LAYERS-1:0]       out_layer
);

    logic [`VDP_COLOR_W-1:0] mem [`VDP_PALETTE_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, layer travels with the colour lookup
    always_ff @(posedge clk) begin
        out_color <= mem[rd_select.pixel];
        out_layer <= rd_select.layer;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_valid;
        end
    end

    // selection built upstream must never name two layers at once
    a_select_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> $onehot0(rd_select.layer));

endmodule

/* logic/vdp_ctrl_regs.sv */
// --------------------------------------------------
// AXI4-Lite slave for compositor configuration
// layer-enable register, palette write forwarding
// --------------------------------------------------
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_ctrl_regs (
    input  logic                        clk,
    input  logic                        arst_n,
    input  vdp_bus_pkg::axil_req_t      axil_req,
    output vdp_bus_pkg::axil_rsp_t      axil_rsp,
    output logic [`VDP_LAYERS-1:0]      layer_en,
    output logic                        pal_we,
    output logic [`VDP_PIXEL_W-1:0]     pal_addr,
    output logic [`VDP_COLOR_W-1:0]     pal_wdata
);

    localparam logic [11:0] PAL_BASE = `VDP_REG_PALETTE_BASE;

    typedef enum logic [1:0] {
        IDLE,
        WRESP,
        RRESP
    } state_e;

    state_e                  state;
    logic                    wr_accept;
    logic                    rd_accept;
    logic                    wr_is_en;
    logic                    wr_is_pal;
    logic                    rd_is_en;
    vdp_bus_pkg::axil_resp_e bresp_q;
    vdp_bus_pkg::axil_resp_e rresp_q;
    logic [31:0]             rdata_q;

    // aw and w are taken together, writes win over a pending read
    assign wr_accept = (state == IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_accept = (state == IDLE) && !wr_accept && axil_req.arvalid;

    // address decode, palette spans 0x400..0x7fc
    assign wr_is_en  = (axil_req.awaddr == `VDP_REG_LAYER_EN);
    assign wr_is_pal = (axil_req.awaddr[11:10] == PAL_BASE[11:10]);
    assign rd_is_en  = (axil_req.araddr == `VDP_REG_LAYER_EN);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            layer_en <= '1;
            pal_we   <= 1'b0;
        end else begin
            pal_we <= wr_accept && wr_is_pal && (axil_req.wstrb[1:0] != 2'b00);
            if (wr_accept && wr_is_en && axil_req.wstrb[0]) begin
                layer_en <= axil_req.wdata[`VDP_LAYERS-1:0];
            end
            case (state)
                IDLE: begin
                    if (wr_accept) begin
                        state <= WRESP;
                    end else if (rd_accept) begin
                        state <= RRESP;
                    end
                end
                WRESP: if (axil_req.bready) state <= IDLE;
                RRESP: if (axil_req.rready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // response and palette payload, captured at acceptance
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp_q   <= (wr_is_en || wr_is_pal) ? vdp_bus_pkg::OKAY : vdp_bus_pkg::SLVERR;
            pal_addr  <= axil_req.awaddr[9:2];
            pal_wdata <= axil_req.wdata[`VDP_COLOR_W-1:0];
        end
        if (rd_accept) begin
            // palette is write-only so only the enable register reads back
            rresp_q <= rd_is_en ? vdp_bus_pkg::OKAY : vdp_bus_pkg::SLVERR;
            rdata_q <= rd_is_en ? 32'(layer_en) : 32'h0;
        end
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.arready = rd_accept;
        axil_rsp.bvalid  = (state == WRESP);
        axil_rsp.bresp   = bresp_q;
        axil_rsp.rvalid  = (state == RRESP);
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rdata   = rdata_q;
    end

    // responses are held until the master takes them
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid);

endmodule

/* logic/vdp_compositor.sv */
// --------------------------------------------------
// compositor top level
// opacity, priority and palette stages
// plus the AXI4-Lite register block
// --------------------------------------------------
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_compositor (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         pix_valid,
    input  vdp_layer_pkg::layer_pixels_t pix_in,
    output logic                         out_valid,
    output logic [`VDP_COLOR_W-1:0]      out_color,
    output logic [`VDP_LAYERS-1:0]       out_layer,
    input  vdp_bus_pkg::axil_req_t       axil_req,
    output vdp_bus_pkg::axil_rsp_t       axil_rsp
);

    logic [`VDP_LAYERS-1:0]       layer_en;
    logic                         pal_we;
    logic [`VDP_PIXEL_W-1:0]      pal_addr;
    logic [`VDP_COLOR_W-1:0]      pal_wdata;
    // stage 1 outputs
    logic                         mask_valid;
    vdp_layer_pkg::layer_pixels_t pixels;
    logic [`VDP_LAYERS-1:0]       layer_mask;
    vdp_layer_pkg::layer_select_t selection;

    vdp_ctrl_regs regs0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .layer_en  (layer_en),
        .pal_we    (pal_we),
        .pal_addr  (pal_addr),
        .pal_wdata (pal_wdata)
    );

    vdp_layer_opacity opacity0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .pix_valid  (pix_valid),
        .pix_in     (pix_in),
        .layer_en   (layer_en),
        .mask_valid (mask_valid),
        .pixels     (pixels),
        .layer_mask (layer_mask)
    );

    // resolves within the same cycle as the stage 1 registers
    vdp_layer_priority_select select0 (
        .layer_mask (layer_mask),
        .pixels     (pixels),
        .selection  (selection)
    );

    vdp_palette_ram palette0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_valid  (mask_valid),
        .rd_select (selection),
        .we        (pal_we),
        .waddr     (pal_addr),
        .wdata     (pal_wdata),
        .out_valid (out_valid),
        .out_color (out_color),
        .out_layer (out_layer)
    );

endmodule

/* verification/vdp_compositor_tb.sv */
// --------------------------------------------------
// directed testbench for the compositor
// AXI4-Lite and pixel drivers, reference model,
// output monitor, LCG stimulus and a watchdog
// --------------------------------------------------
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_compositor_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int HS_LIMIT     = 20;
    // palette load, register accesses and pixels over all tests
    localparam int TRANSACTIONS = 520;
    localparam int TIMEOUT_NS   = TRANSACTIONS * 20 * CLK_PERIOD;

    // expected output of one pixel stamped with its arrival cycle
    typedef struct packed {
        logic [31:0]             stamp;
        logic [`VDP_COLOR_W-1:0] color;
        logic [`VDP_LAYERS-1:0]  layer;
    } expected_t;

    logic                         clk;
    logic                         arst_n;
    logic                         pix_valid;
    vdp_layer_pkg::layer_pixels_t pix_in;
    logic                         out_valid;
    logic [`VDP_COLOR_W-1:0]      out_color;
    logic [`VDP_LAYERS-1:0]       out_layer;
    vdp_bus_pkg::axil_req_t       axil_req;
    vdp_bus_pkg::axil_rsp_t       axil_rsp;

    // tb view of the palette and the enable register
    logic [`VDP_COLOR_W-1:0] pal_shadow [`VDP_PALETTE_DEPTH];
    logic [`VDP_LAYERS-1:0]  en_shadow;
    expected_t               exp_q [$];
    int                      cyc;
    int                      checks;
    int                      errors;
    int                      test_err_base;
    string                   cur_test;
    logic [31:0]             lcg_state;

    vdp_compositor dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix_valid (pix_valid),
        .pix_in    (pix_in),
        .out_valid (out_valid),
        .out_color (out_color),
        .out_layer (out_layer),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc++;
        end
    end

    // watchdog sized from the transaction count
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = errors;
    endtask

    task automatic finish_test();
        $display("%s finished with %0d errors", cur_test, errors - test_err_base);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // reference rule picks the top opaque scroll layer unless the sprite outranks it
    function automatic logic [12:0] model_select(input vdp_layer_pkg::layer_pixels_t p,
                                                 input logic [`VDP_LAYERS-1:0] en);
        logic [4:0] opaque;
        logic [4:0] win;
        logic [7:0] idx;
        int         top;
        for (int n = 0; n < 4; n++) begin
            opaque[n] = en[n] && (p.scroll[n][3:0] != 4'h0);
        end
        opaque[4] = en[4] && (p.sprite[3:0] != 4'h0);
        top = -1;
        for (int n = 3; n >= 0; n--) begin
            if (opaque[n]) top = n;
        end
        win = 5'b0;
        idx = 8'h00;
        if (opaque[4] && (top < 0 || int'(p.sprite_prio) + top > 3)) begin
            win[4] = 1'b1;
            idx    = p.sprite;
        end else if (top >= 0) begin
            win[top] = 1'b1;
            idx      = p.scroll[top];
        end
        return {win, idx};
    endfunction

    function automatic vdp_layer_pkg::layer_pixels_t make_pixels(
        input logic [7:0] s0, input logic [7:0] s1, input logic [7:0] s2,
        input logic [7:0] s3, input logic [7:0] sp, input logic [1:0] prio);
        vdp_layer_pkg::layer_pixels_t p;
        p.scroll[0]   = s0;
        p.scroll[1]   = s1;
        p.scroll[2]   = s2;
        p.scroll[3]   = s3;
        p.sprite      = sp;
        p.sprite_prio = prio;
        return p;
    endfunction

    // aw and w go out together and bready stays high so b completes on the first bvalid
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int   waited;
        logic taken;
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        // ready is combinational, settled well before the next rising edge
        #(CLK_PERIOD / 4);
        taken = axil_rsp.awready && axil_rsp.wready;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!axil_rsp.bvalid && waited < HS_LIMIT);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        check_equal("awready and wready on idle bus", 32'h1, 32'(taken));
        resp = 2'b11;
        if (axil_rsp.bvalid) resp = axil_rsp.bresp;
        else report_failure("write response never arrived");
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int   waited;
        logic taken;
        @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        #(CLK_PERIOD / 4);
        taken = axil_rsp.arready;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!axil_rsp.rvalid && waited < HS_LIMIT);
        axil_req.arvalid = 1'b0;
        check_equal("arready on idle bus", 32'h1, 32'(taken));
        resp = 2'b11;
        data = 32'hx;
        if (axil_rsp.rvalid) begin
            resp = axil_rsp.rresp;
            data = axil_rsp.rdata;
        end else begin
            report_failure("read data never arrived");
        end
    endtask

    task automatic set_layer_enable(input logic [`VDP_LAYERS-1:0] en);
        logic [1:0] resp;
        axil_write(`VDP_REG_LAYER_EN, 32'(en), resp);
        check_equal("enable write resp", 32'(vdp_bus_pkg::OKAY), 32'(resp));
        en_shadow = en;
    endtask

    // one pixel per call and back to back when called in a row
    task automatic send_pixel(input vdp_layer_pkg::layer_pixels_t p);
        logic [12:0] sel;
        expected_t   e;
        @(negedge clk);
        pix_in    = p;
        pix_valid = 1'b1;
        sel       = model_select(p, en_shadow);
        e.stamp   = 32'(cyc + 2);
        e.layer   = sel[12:8];
        e.color   = pal_shadow[sel[7:0]];
        exp_q.push_back(e);
    endtask

    task automatic wait_drain();
        int waited;
        @(negedge clk);
        pix_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_failure("pixels still pending long after the input stopped");
            exp_q.delete();
        end
    endtask

    // monitor samples at the falling edge where outputs are stable
    initial begin
        expected_t head;
        forever begin
            @(negedge clk);
            if (arst_n && out_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("out_valid high with no pixel in flight");
                end else begin
                    head = exp_q.pop_front();
                    check_equal("latency cycle", head.stamp, 32'(cyc));
                    check_equal("out_layer", 32'(head.layer), 32'(out_layer));
                    check_equal("out_color", 32'(head.color), 32'(out_color));
                end
            end else if (arst_n && exp_q.size() != 0 && exp_q[0].stamp <= 32'(cyc)) begin
                report_failure("pixel output missing at its expected cycle");
                head = exp_q.pop_front();
            end
        end
    end

    task automatic reset_and_registers();
        logic [31:0] data;
        logic [1:0]  resp;
        start_test("reset_and_registers");
        // no handshake or pixel output is active straight out of reset
        check_equal("idle outputs after reset", 32'h0,
                    32'({axil_rsp.awready, axil_rsp.wready, axil_rsp.arready,
                         axil_rsp.bvalid, axil_rsp.rvalid, out_valid}));
        axil_read(`VDP_REG_LAYER_EN, data, resp);
        check_equal("enable reset value", 32'h1f, data);
        check_equal("enable read resp", 32'(vdp_bus_pkg::OKAY), 32'(resp));
        set_layer_enable(5'h0a);
        axil_read(`VDP_REG_LAYER_EN, data, resp);
        check_equal("enable readback", 32'h0a, data);
        set_layer_enable(5'h1f);
        // palette is write-only
        axil_read(12'h404, data, resp);
        check_equal("palette read resp", 32'(vdp_bus_pkg::SLVERR), 32'(resp));
        axil_write(12'h100, 32'h0, resp);
        check_equal("unmapped write resp", 32'(vdp_bus_pkg::SLVERR), 32'(resp));
        axil_read(`VDP_REG_LAYER_EN, data, resp);
        check_equal("enable after unmapped write", 32'h1f, data);
        finish_test();
    endtask

    task automatic load_palette();
        logic [1:0] resp;
        start_test("load_palette");
        for (int i = 0; i < `VDP_PALETTE_DEPTH; i++) begin
            pal_shadow[i] = 16'(i * 16'h0101);
            axil_write(12'(`VDP_REG_PALETTE_BASE + 4 * i), 32'(pal_shadow[i]), resp);
            check_equal("palette write resp", 32'(vdp_bus_pkg::OKAY), 32'(resp));
        end
        finish_test();
    endtask

    task automatic scroll_priority();
        start_test("scroll_priority");
        // transparent sprite at top priority must not matter
        send_pixel(make_pixels(8'h12, 8'h24, 8'h36, 8'h48, 8'h60, 2'd3));
        send_pixel(make_pixels(8'h10, 8'h24, 8'h36, 8'h48, 8'h60, 2'd3));
        send_pixel(make_pixels(8'h10, 8'h20, 8'h36, 8'h48, 8'h60, 2'd3));
        send_pixel(make_pixels(8'h10, 8'h20, 8'h30, 8'h48, 8'h60, 2'd3));
        wait_drain();
        finish_test();
    endtask

    task automatic sprite_priority();
        vdp_layer_pkg::layer_pixels_t p;
        start_test("sprite_priority");
        for (int prio = 0; prio < 4; prio++) begin
            for (int n = 0; n < 4; n++) begin
                p = make_pixels(8'h10, 8'h20, 8'h30, 8'h40, 8'(8'h83 + 16 * prio), 2'(prio));
                p.scroll[n] = 8'(8'h21 + 16 * n);
                send_pixel(p);
            end
        end
        wait_drain();
        finish_test();
    endtask

    task automatic transparency_enables();
        start_test("transparency_enables");
        // zero low nibbles everywhere give the backdrop
        send_pixel(make_pixels(8'h10, 8'h20, 8'h30, 8'h40, 8'h50, 2'd2));
        wait_drain();
        set_layer_enable(5'h00);
        send_pixel(make_pixels(8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 2'd3));
        wait_drain();
        set_layer_enable(5'h04);
        send_pixel(make_pixels(8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 2'd3));
        wait_drain();
        // sprite alone wins at priority 0
        set_layer_enable(5'h10);
        send_pixel(make_pixels(8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 2'd0));
        wait_drain();
        set_layer_enable(5'h1f);
        finish_test();
    endtask

    task automatic random_stream();
        logic [31:0] r1;
        logic [31:0] r2;
        start_test("random_stream");
        for (int blk = 0; blk < 4; blk++) begin
            r1 = lcg_next();
            set_layer_enable(r1[31:27]);
            for (int i = 0; i < 50; i++) begin
                r1 = lcg_next();
                r2 = lcg_next();
                send_pixel(make_pixels(r1[31:24], r1[23:16], r1[15:8],
                                       r2[31:24], r2[23:16], r2[15:14]));
            end
            wait_drain();
        end
        set_layer_enable(5'h1f);
        finish_test();
    endtask

    task automatic palette_update();
        logic [1:0] resp;
        start_test("palette_update");
        send_pixel(make_pixels(8'h35, 8'h20, 8'h30, 8'h40, 8'h50, 2'd0));
        wait_drain();
        axil_write(12'(`VDP_REG_PALETTE_BASE + 4 * 'h35), 32'h0000_beef, resp);
        check_equal("palette rewrite resp", 32'(vdp_bus_pkg::OKAY), 32'(resp));
        pal_shadow[8'h35] = 16'hbeef;
        send_pixel(make_pixels(8'h35, 8'h20, 8'h30, 8'h40, 8'h50, 2'd0));
        // neighbour entry keeps its colour
        send_pixel(make_pixels(8'h36, 8'h20, 8'h30, 8'h40, 8'h50, 2'd0));
        wait_drain();
        finish_test();
    endtask

    initial begin
        arst_n        = 1'b0;
        pix_valid     = 1'b0;
        pix_in        = '0;
        axil_req      = '0;
        en_shadow     = 5'h1f;
        checks        = 0;
        errors        = 0;
        test_err_base = 0;
        cur_test      = "reset";
        lcg_state     = 32'd57;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        reset_and_registers();
        load_palette();
        scroll_priority();
        sprite_priority();
        transparency_enables();
        random_stream();
        palette_update();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
logic/vdp_layer_pkg.sv
logic/vdp_bus_pkg.sv
logic/vdp_layer_opacity.sv
logic/vdp_layer_priority_select.sv
logic/vdp_palette_ram.sv
logic/vdp_ctrl_regs.sv
logic/vdp_compositor.sv
verification/vdp_compositor_tb.sv

/* Makefile */
# Verilator build and run of the compositor testbench
TOP := vdp_compositor_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
